// File: hdl/fetch_pkg.sv
package fetch_pkg;

	// --------------------------------------------------
	// widths and depths

	localparam int w_addr = 32;
	localparam int w_data = 32;
	localparam int w_half = 16;

	// two entries are enough to keep fetching at full rate while decode stalls
	localparam int fifo_depth = 2;

	typedef logic [w_addr-1:0] addr_t;
	typedef logic [w_data-1:0] word_t;
	typedef logic [w_half-1:0] half_t;

	// one flag per halfword of a fetch word, bit 0 is the lower halfword
	typedef logic [1:0] hw_vld_t;

	// a count of halfwords between 0 and 2
	typedef logic [1:0] cir_cnt_t;

	// the first fetch after reset goes here
	localparam addr_t reset_vector = 32'h0000_0040;

	// --------------------------------------------------
	// bus and pipeline records

	// address phase of the fetch bus
	typedef struct packed {
		addr_t addr;
		logic  valid;
	} mem_req_t;

	// data phase of the fetch bus, answered in order
	typedef struct packed {
		word_t data;
		logic  err;
		logic  valid;
	} mem_resp_t;

	// redirect request from the core
	typedef struct packed {
		addr_t target;
		logic  valid;
	} jump_req_t;

	// one fetched word on its way from the bus or the queue into the buffer
	typedef struct packed {
		word_t   data;
		hw_vld_t hw_vld;
		logic    err;
	} fetch_beat_t;

	// one halfword entry of the instruction buffer with its bus error flag
	typedef struct packed {
		logic  err;
		half_t half;
	} slot_t;

endpackage

// File: hdl/fetch_request.sv
`timescale 1ns/10ps

module fetch_request (
	input  logic                  clk,
	input  logic                  rst_n,
	input  fetch_pkg::jump_req_t  jump,
	output logic                  jump_target_rdy,
	output fetch_pkg::mem_req_t   mem_req,
	input  logic                  mem_addr_rdy,
	input  logic                  fetch_stall,
	output logic                  jump_now,
	output logic                  fetch_accept,
	output fetch_pkg::hw_vld_t    dph_hw_vld
);

	// the fetch address counts ahead of the pc in whole words
	fetch_pkg::addr_t   fetch_addr;
	fetch_pkg::addr_t   jump_word;
	fetch_pkg::hw_vld_t aph_hw_vld;
	logic               addr_hold;
	logic               jump_odd;

	// requests on the bus are always word aligned
	assign jump_word = {jump.target[fetch_pkg::w_addr-1:2], 2'b00};
	assign jump_odd  = jump.target[1];

	// a held address phase must not be disturbed, so jumps wait until it is taken
	assign jump_target_rdy = !addr_hold;
	assign jump_now        = jump.valid && jump_target_rdy;
	assign fetch_accept    = mem_req.valid && mem_addr_rdy;

	// --------------------------------------------------
	// address phase

	// a held request stays as it is, otherwise a pending jump puts its target
	// straight onto the bus in the same cycle
	always_comb begin
		mem_req.addr  = fetch_addr;
		mem_req.valid = addr_hold || !fetch_stall;
		if (!addr_hold && jump.valid) begin
			mem_req.addr = jump_word;
		end
	end

	// remember that the bus saw a request it did not take
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_hold <= 1'b0;
		end else begin
			addr_hold <= mem_req.valid && !mem_addr_rdy;
		end
	end

	// if the target went through this cycle the counter moves one word past it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= fetch_pkg::reset_vector;
		end else if (jump_now) begin
			fetch_addr <= jump_word +
				(fetch_accept ? fetch_pkg::addr_t'(4) : fetch_pkg::addr_t'(0));
		end else if (fetch_accept) begin
			fetch_addr <= fetch_addr + fetch_pkg::addr_t'(4);
		end
	end

	// --------------------------------------------------
	// halfword validity

	// a jump to an odd halfword leaves the lower half of its first word unused
	// the flag follows the address phase and moves to the data phase on accept
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aph_hw_vld <= 2'b11;
			dph_hw_vld <= 2'b11;
		end else if (jump_now) begin
			if (fetch_accept) begin
				aph_hw_vld <= 2'b11;
				dph_hw_vld <= {1'b1, !jump_odd};
			end else begin
				aph_hw_vld <= {1'b1, !jump_odd};
			end
		end else if (fetch_accept) begin
			dph_hw_vld <= aph_hw_vld;
			aph_hw_vld <= 2'b11;
		end
	end

endmodule

// File: hdl/bus_tracker.sv
`timescale 1ns/10ps

module bus_tracker (
	input  logic clk,
	input  logic rst_n,
	input  logic jump_now,
	input  logic fetch_accept,
	input  logic mem_data_vld,
	input  logic queue_full,
	input  logic queue_almost_full,
	input  logic queue_empty,
	input  logic buf_room,
	output logic fetch_stall,
	output logic fifo_push,
	output logic data_live
);

	// fetches accepted by the bus whose data has not come back yet
	logic [1:0] pending;
	// responses still owed from before the last jump, these get dropped
	logic [1:0] flush_cnt;
	// set from a jump until the first word after it has returned
	logic       jump_wait;

	// a response is live once every stale one ahead of it has been dropped
	assign data_live = mem_data_vld && flush_cnt == 2'd0;

	// the queue has to be able to hold everything already in flight
	// while the first word after a jump is out, only that one fetch is allowed so
	// its halfword validity stays on the data phase until it lands
	assign fetch_stall = queue_full
		|| (queue_almost_full && pending != 2'd0)
		|| pending[1]
		|| (jump_wait && pending != 2'd0);

	// a word that goes straight into the buffer must not also enter the queue
	assign fifo_push = data_live && !(buf_room && queue_empty);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending   <= 2'd0;
			flush_cnt <= 2'd0;
			jump_wait <= 1'b0;
		end else begin
			pending <= pending + 2'(fetch_accept) - 2'(mem_data_vld);
			if (jump_now) begin
				flush_cnt <= pending - 2'(mem_data_vld);
				jump_wait <= 1'b1;
			end else begin
				if (flush_cnt != 2'd0 && mem_data_vld) begin
					flush_cnt <= flush_cnt - 2'd1;
				end
				if (data_live) begin
					jump_wait <= 1'b0;
				end
			end
		end
	end

endmodule

// File: hdl/prefetch_queue.sv
`timescale 1ns/10ps

module prefetch_queue (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   jump_now,
	input  logic                   push,
	input  logic                   pop,
	input  fetch_pkg::fetch_beat_t in_beat,
	output fetch_pkg::fetch_beat_t head,
	output logic                   empty,
	output logic                   full,
	output logic                   almost_full
);

	localparam int depth = fetch_pkg::fifo_depth;

	// entry 0 is always the oldest, and valid entries are packed towards it
	fetch_pkg::word_t       q_data [depth];
	logic                   q_err  [depth];
	fetch_pkg::hw_vld_t     q_hw   [depth];

	// the entries plus one empty slot past the end, so every entry has a
	// neighbour to shift from
	fetch_pkg::fetch_beat_t ext    [depth+1];
	logic [depth:0]         vld;
	// validity of the entry below, which is always true for entry 0
	logic [depth-1:0]       vld_m1;

	always_comb begin
		for (int i = 0; i < depth; i++) begin
			ext[i] = '{data: q_data[i], hw_vld: q_hw[i], err: q_err[i]};
		end
		ext[depth] = '{data: in_beat.data, hw_vld: 2'b00, err: in_beat.err};
		for (int i = 0; i <= depth; i++) begin
			vld[i] = |ext[i].hw_vld;
		end
		vld_m1 = {vld[depth-2:0], 1'b1};
	end

	assign head        = ext[0];
	assign empty       = !vld[0];
	assign full        = vld[depth-1];
	assign almost_full = vld[depth-2];

	// --------------------------------------------------
	// payload

	// an entry loads when the queue moves down or when it is the free slot a
	// push lands in, taking its neighbour if that is valid and the bus otherwise
	always_ff @(posedge clk) begin
		for (int i = 0; i < depth; i++) begin
			if (pop || (push && !vld[i])) begin
				q_data[i] <= vld[i+1] ? ext[i+1].data : in_beat.data;
				q_err[i]  <= vld[i+1] ? ext[i+1].err : in_beat.err;
			end
		end
	end

	// --------------------------------------------------
	// validity

	// a jump empties the queue, otherwise entries shift down on pop and the
	// push fills the lowest free entry
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < depth; i++) begin
				q_hw[i] <= 2'b00;
			end
		end else begin
			for (int i = 0; i < depth; i++) begin
				if (jump_now) begin
					q_hw[i] <= 2'b00;
				end else if (vld[i+1] && pop) begin
					q_hw[i] <= ext[i+1].hw_vld;
				end else if (vld[i] && pop) begin
					q_hw[i] <= in_beat.hw_vld & {2{push}};
				end else if (vld[i]) begin
					q_hw[i] <= q_hw[i];
				end else if (push && !pop && vld_m1[i]) begin
					q_hw[i] <= in_beat.hw_vld;
				end else begin
					q_hw[i] <= 2'b00;
				end
			end
		end
	end

endmodule

// File: hdl/instr_buffer.sv
`timescale 1ns/10ps

module instr_buffer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   jump_now,
	input  fetch_pkg::fetch_beat_t bus_beat,
	input  logic                   data_live,
	input  fetch_pkg::fetch_beat_t queue_head,
	input  logic                   queue_empty,
	output logic                   buf_room,
	output logic                   fifo_pop,
	input  fetch_pkg::cir_cnt_t    cir_use,
	output fetch_pkg::word_t       cir,
	output fetch_pkg::cir_cnt_t    cir_vld,
	output fetch_pkg::hw_vld_t     cir_err
);

	// three halfword slots, the lower two form the decode window and the
	// third lets the window sit on any halfword boundary
	fetch_pkg::slot_t [2:0]  buf_q;
	fetch_pkg::slot_t [2:0]  buf_shifted;
	fetch_pkg::slot_t [2:0]  buf_next;
	fetch_pkg::slot_t [1:0]  fetch_aligned;
	fetch_pkg::fetch_beat_t  fetch_beat;
	logic                    fetch_vld;
	logic [1:0]              buf_level;
	logic [1:0]              level_no_fetch;
	logic [1:0]              fill;
	logic [1:0]              level_next;

	// --------------------------------------------------
	// fetch source

	// the queue holds older data than the bus, so the bus only feeds the
	// buffer directly while the queue is empty
	assign fetch_beat = queue_empty ? bus_beat : queue_head;
	assign fetch_vld  = !queue_empty || data_live;

	// a word whose lower halfword is invalid gets its upper half moved down
	assign fetch_aligned[1] = '{err: fetch_beat.err, half: fetch_beat.data[31:16]};
	assign fetch_aligned[0] = fetch_beat.hw_vld[0] ? '{err: fetch_beat.err,
		half: fetch_beat.data[15:0]} : fetch_aligned[1];

	// --------------------------------------------------
	// shift and overlay

	// only the slots that stay valid matter after the shift, the rest are
	// either overwritten or ignored
	always_comb begin
		if (cir_use[1]) begin
			buf_shifted = {buf_q[2], buf_q[1], buf_q[2]};
		end else if (cir_use[0]) begin
			buf_shifted = {buf_q[2], buf_q[2], buf_q[1]};
		end else begin
			buf_shifted = buf_q;
		end
	end

	assign level_no_fetch = buf_level - cir_use;

	// a half word needs one free slot, a full word needs two
	assign buf_room = level_no_fetch <= (&fetch_beat.hw_vld ? 2'd1 : 2'd2);
	assign fifo_pop = buf_room && !queue_empty;

	// fresh data goes in right above whatever is left after consumption
	always_comb begin
		if (!buf_room) begin
			buf_next = buf_shifted;
		end else if (level_no_fetch[1]) begin
			buf_next = {fetch_aligned[0], buf_shifted[1:0]};
		end else if (level_no_fetch[0]) begin
			buf_next = {fetch_aligned, buf_shifted[0]};
		end else begin
			buf_next = {buf_shifted[2], fetch_aligned};
		end
	end

	assign fill = (buf_room && fetch_vld) ? (&fetch_beat.hw_vld ? 2'd2 : 2'd1) : 2'd0;
	assign level_next = jump_now ? 2'd0 : level_no_fetch + fill;

	// --------------------------------------------------
	// state

	always_ff @(posedge clk) begin
		buf_q <= buf_next;
	end

	// the decode window shows at most two halfwords even when three are held
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld   <= 2'd0;
		end else begin
			buf_level <= level_next;
			cir_vld   <= level_next & ~(level_next >> 1);
		end
	end

	assign cir     = {buf_q[1].half, buf_q[0].half};
	assign cir_err = {buf_q[1].err, buf_q[0].err};

endmodule

// File: hdl/fetch_frontend.sv
`timescale 1ns/10ps

module fetch_frontend (
	input  logic                 clk,
	input  logic                 rst_n,
	output fetch_pkg::mem_req_t  mem_req,
	input  logic                 mem_addr_rdy,
	input  fetch_pkg::mem_resp_t mem_resp,
	input  fetch_pkg::jump_req_t jump,
	output logic                 jump_target_rdy,
	input  fetch_pkg::cir_cnt_t  cir_use,
	output fetch_pkg::word_t     cir,
	output fetch_pkg::cir_cnt_t  cir_vld,
	output fetch_pkg::hw_vld_t   cir_err
);

	logic                   jump_now, fetch_accept, fetch_stall;
	logic                   fifo_push, fifo_pop, data_live, buf_room;
	logic                   queue_empty, queue_full, queue_almost_full;
	fetch_pkg::hw_vld_t     dph_hw_vld;
	fetch_pkg::fetch_beat_t bus_beat, queue_head;

	// the bus word picks up the halfword validity of its data phase
	assign bus_beat = '{data: mem_resp.data, hw_vld: dph_hw_vld, err: mem_resp.err};

	fetch_request u_request (.clk, .rst_n, .jump, .jump_target_rdy, .mem_req,
		.mem_addr_rdy, .fetch_stall, .jump_now, .fetch_accept, .dph_hw_vld);

	bus_tracker u_tracker (.clk, .rst_n, .jump_now, .fetch_accept,
		.mem_data_vld(mem_resp.valid), .queue_full, .queue_almost_full, .queue_empty,
		.buf_room, .fetch_stall, .fifo_push, .data_live);

	prefetch_queue u_queue (.clk, .rst_n, .jump_now, .push(fifo_push), .pop(fifo_pop),
		.in_beat(bus_beat), .head(queue_head), .empty(queue_empty), .full(queue_full),
		.almost_full(queue_almost_full));

	instr_buffer u_buffer (.clk, .rst_n, .jump_now, .bus_beat, .data_live, .queue_head,
		.queue_empty, .buf_room, .fifo_pop, .cir_use, .cir, .cir_vld, .cir_err);

endmodule

// File: tests/tb_fetch_frontend.sv
`timescale 1ns/10ps

module tb_fetch_frontend;

	logic                 clk;
	logic                 rst_n;
	fetch_pkg::mem_req_t  mem_req;
	logic                 mem_addr_rdy;
	fetch_pkg::mem_resp_t mem_resp;
	fetch_pkg::jump_req_t jump;
	logic                 jump_target_rdy;
	fetch_pkg::cir_cnt_t  cir_use;
	fetch_pkg::word_t     cir;
	fetch_pkg::cir_cnt_t  cir_vld;
	fetch_pkg::hw_vld_t   cir_err;

	// memory image with a bus error flag per word
	fetch_pkg::word_t img_data [fetch_pkg::addr_t];
	logic             img_err [fetch_pkg::addr_t];
	// instructions per segment, and the jump target that closes each segment
	int               seg_cnt [$];
	fetch_pkg::addr_t jump_dest [$];
	// fetches the bus has accepted and not yet answered, with their due cycle
	fetch_pkg::addr_t pend_addr [$];
	int               pend_due [$];

	int               seed = 32'h9236;
	fetch_pkg::addr_t pc;
	fetch_pkg::addr_t addr_seen;
	logic             took_addr;
	logic             took_jump;
	logic             first_fetch = 1'b1;
	int               seg_idx;
	int               seg_left;
	int               consumed = 0;
	int               total;
	int               limit;
	int               cycle = 0;

	fetch_frontend uut (.clk, .rst_n, .mem_req, .mem_addr_rdy, .mem_resp, .jump,
		.jump_target_rdy, .cir_use, .cir, .cir_vld, .cir_err);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// reporting

	task automatic fail_value(input string name, input fetch_pkg::word_t got,
		input fetch_pkg::word_t exp);
		$display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic fail_run(input string what);
		$display("Error at %0d ns: %s", $time, what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input fetch_pkg::word_t got,
		input fetch_pkg::word_t exp);
		if (got !== exp) begin
			fail_value(name, got, exp);
		end
	endtask

	task automatic check_flags(input string name, input fetch_pkg::hw_vld_t got,
		input fetch_pkg::hw_vld_t exp);
		if (got !== exp) begin
			fail_value(name, fetch_pkg::word_t'(got), fetch_pkg::word_t'(exp));
		end
	endtask

	task automatic check_count(input string name, input fetch_pkg::cir_cnt_t got,
		input fetch_pkg::cir_cnt_t exp);
		if (got !== exp) begin
			fail_value(name, fetch_pkg::word_t'(got), fetch_pkg::word_t'(exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_value(name, fetch_pkg::word_t'(got), fetch_pkg::word_t'(exp));
		end
	endtask

	// --------------------------------------------------
	// memory image

	// addresses outside the image read back a pattern built from the whole address
	function automatic fetch_pkg::word_t word_at(input fetch_pkg::addr_t a);
		if (img_data.exists(a)) begin
			return img_data[a];
		end
		return a ^ 32'hc3a5_96e1;
	endfunction

	function automatic logic err_at(input fetch_pkg::addr_t a);
		fetch_pkg::addr_t w;
		w = {a[31:2], 2'b00};
		return img_err.exists(w) ? img_err[w] : 1'b0;
	endfunction

	function automatic fetch_pkg::half_t half_at(input fetch_pkg::addr_t a);
		fetch_pkg::word_t w;
		w = word_at({a[31:2], 2'b00});
		return a[1] ? w[31:16] : w[15:0];
	endfunction

	// value of one hex digit character, or -1 for any other character
	function automatic int hex_value(input byte ch);
		if (ch >= "0" && ch <= "9") begin
			return ch - "0";
		end
		if (ch >= "a" && ch <= "f") begin
			return ch - "a" + 10;
		end
		if (ch >= "A" && ch <= "F") begin
			return ch - "A" + 10;
		end
		return -1;
	endfunction

	// each record is a kind digit and two 32 bit fields in 17 hex digits
	// anything after a slash is a comment, and other characters are skipped
	task automatic load_cases();
		int          fd;
		int          digits;
		int          nib;
		byte         ch;
		string       line;
		logic [67:0] rec;
		logic        in_comment;
		logic        found_end;
		fd = $fopen("tests/fetch_cases.txt", "r");
		if (fd == 0) begin
			fail_run("the case file cannot be opened");
		end
		found_end = 1'b0;
		line = "";
		while (!found_end && $fgets(line, fd) != 0) begin
			rec        = '0;
			digits     = 0;
			in_comment = 1'b0;
			for (int k = 0; k < line.len(); k++) begin
				ch = line.getc(k);
				if (ch == "/") begin
					in_comment = 1'b1;
				end
				nib = hex_value(ch);
				if (!in_comment && nib >= 0) begin
					rec    = {rec[63:0], nib[3:0]};
					digits = digits + 1;
				end
			end
			if (digits != 0) begin
				if (digits != 17) begin
					fail_run("a case record does not hold 17 hex digits");
				end
				case (rec[67:64])
					4'h1, 4'h2: begin
						img_data[rec[63:32]] = rec[31:0];
						img_err[rec[63:32]]  = rec[67:64] == 4'h2;
					end
					4'h3: begin
						seg_cnt.push_back(int'(rec[63:32]));
						jump_dest.push_back(rec[31:0]);
					end
					4'h4: begin
						seg_cnt.push_back(int'(rec[63:32]));
						found_end = 1'b1;
					end
					default: fail_run("the case file holds a record of unknown kind");
				endcase
			end
		end
		$fclose(fd);
		if (!found_end) begin
			fail_run("the case file has no end record");
		end
		total = 0;
		foreach (seg_cnt[k]) begin
			total += seg_cnt[k];
		end
		// each expected instruction gets a generous budget of cycles
		limit    = 60 * total;
		pc       = fetch_pkg::reset_vector;
		seg_idx  = 0;
		seg_left = seg_cnt[0];
	endtask

	// --------------------------------------------------
	// bus and decode models

	// retire the response taken at this edge, log a new address and drive the
	// head response once it is due
	task automatic serve_bus(input logic took, input fetch_pkg::addr_t addr);
		int lat;
		lat = 1 + ($random(seed) & 1);
		if (mem_resp.valid) begin
			void'(pend_addr.pop_front());
			void'(pend_due.pop_front());
		end
		if (took) begin
			if (first_fetch) begin
				check_word("mem_req.addr", addr, fetch_pkg::reset_vector);
				first_fetch = 1'b0;
			end
			if (addr[1:0] != 2'b00) begin
				fail_run("a fetch address is not word aligned");
			end
			pend_addr.push_back(addr);
			pend_due.push_back(cycle + lat - 1);
			if (pend_addr.size() > 2) begin
				fail_run("more than two fetches are outstanding on the bus");
			end
		end
		mem_resp = '0;
		if (pend_addr.size() != 0 && pend_due[0] <= cycle) begin
			mem_resp = '{data: word_at(pend_addr[0]), err: err_at(pend_addr[0]), valid: 1'b1};
		end
		mem_addr_rdy = ($random(seed) & 3) != 0;
	endtask

	// a halfword ending in 11 opens a 32 bit instruction and anything else is compressed
	task automatic step_decode();
		logic             go;
		int               len;
		fetch_pkg::half_t h0;
		go = ($random(seed) & 3) != 0;
		cir_use = 2'd0;
		if (jump.valid) begin
			// the redirect stays up until the front end is ready for it
		end else if (seg_left == 0) begin
			jump = '{target: jump_dest[seg_idx], valid: 1'b1};
		end else if (go) begin
			h0  = half_at(pc);
			len = (h0[1:0] == 2'b11) ? 2 : 1;
			if (int'(cir_vld) >= len) begin
				if (len == 2) begin
					check_word("cir", cir, {half_at(pc + 32'd2), h0});
					check_flags("cir_err", cir_err, {err_at(pc + 32'd2), err_at(pc)});
				end else begin
					check_word("cir[15:0]", cir & 32'h0000_ffff, {16'h0000, h0});
					check_flags("cir_err[0]", cir_err & 2'b01, {1'b0, err_at(pc)});
				end
				cir_use  = fetch_pkg::cir_cnt_t'(len);
				pc       = pc + fetch_pkg::addr_t'(2 * len);
				seg_left = seg_left - 1;
				consumed = consumed + 1;
			end
		end
	endtask

	// --------------------------------------------------
	// main sequence

	initial begin
		rst_n        = 1'b0;
		mem_addr_rdy = 1'b0;
		mem_resp     = '0;
		jump         = '0;
		cir_use      = 2'd0;
		load_cases();
		// reset is held over three rising edges
		repeat (3) begin
			@(posedge clk);
			#1;
			check_count("cir_vld", cir_vld, 2'd0);
			check_bit("jump_target_rdy", jump_target_rdy, 1'b1);
		end
		rst_n        = 1'b1;
		mem_addr_rdy = ($random(seed) & 3) != 0;
		#1;
		check_count("cir_vld", cir_vld, 2'd0);
		check_bit("jump_target_rdy", jump_target_rdy, 1'b1);
		// the first request goes out right away from the reset vector
		check_bit("mem_req.valid", mem_req.valid, 1'b1);
		check_word("mem_req.addr", mem_req.addr, fetch_pkg::reset_vector);
		while (consumed < total) begin
			// handshakes are settled by mid cycle and take effect at the next edge
			@(negedge clk);
			took_addr = mem_req.valid && mem_addr_rdy;
			addr_seen = mem_req.addr;
			took_jump = jump.valid && jump_target_rdy;
			@(posedge clk);
			#1;
			cycle = cycle + 1;
			if (cycle > limit) begin
				fail_run("timeout before the expected instruction stream was consumed");
			end
			serve_bus(took_addr, addr_seen);
			if (took_jump) begin
				check_word("mem_req.addr", addr_seen, {jump.target[31:2], 2'b00});
				pc       = jump.target;
				jump     = '0;
				seg_idx  = seg_idx + 1;
				seg_left = seg_cnt[seg_idx];
			end
			step_decode();
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: tests/fetch_cases.txt
// one kind digit, then field a (8 hex digits), then field b (8 hex digits)
// kind 1 word a holds b, kind 2 same with bus error, kind 3 run a instrs then jump to b, kind 4 run a then stop
10000004000510093
10000004400208113
10000004802934505
10000004c80820012
10000005000b50533
20000005400418193
10000005845854501
10000005c0ff00f6f
100000100 0593beef
100000104460500c5
20000010885264685
10000010c00d60633
10000020007134781
200000204479900f7
10000020800e78793
10000020c00018082
30000000a00000102
30000000500000200
3000000060000004e
40000000400000000

// File: filelist.f
hdl/fetch_pkg.sv
hdl/fetch_request.sv
hdl/bus_tracker.sv
hdl/prefetch_queue.sv
hdl/instr_buffer.sv
hdl/fetch_frontend.sv
tests/tb_fetch_frontend.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_fetch_frontend
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) tests/fetch_cases.txt
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
